//--- src.f
+incdir+include
rtl/resonator_data_pkg.sv
rtl/resonator_ctrl_pkg.sv
rtl/coef_ram.sv
rtl/resonator_seq.sv
rtl/rotation_datapath.sv
rtl/resonator_bank.sv
verif/resonator_asserts.sv
verif/resonator_checker.sv
verif/tb_resonator_bank.sv

//--- Bender.yml
package:
  name: resonator_bank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/resonator_data_pkg.sv
      - rtl/resonator_ctrl_pkg.sv
      - rtl/coef_ram.sv
      - rtl/resonator_seq.sv
      - rtl/rotation_datapath.sv
      - rtl/resonator_bank.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/resonator_asserts.sv
      - verif/resonator_checker.sv
      - verif/tb_resonator_bank.sv

//--- verif/tb_resonator_bank.sv
`timescale 1ns/1ps
`include "resonator_defs.svh"

module tb_resonator_bank;
	import resonator_data_pkg::*;

	localparam int CLK_PERIOD_NS = 4;
	localparam int RESET_CYCLES  = 8;
	localparam int NUM_SAMPLES   = 41;
	localparam int SAMPLE_CYCLES = 3 * `RES_HARM_MAX + 4;
	localparam int WATCHDOG_NS   = NUM_SAMPLES * SAMPLE_CYCLES * CLK_PERIOD_NS + 2000;

	logic        clk_i;
	logic        harmonics_rst;
	logic        coef_we_i;
	coef_addr_t  coef_addr_i;
	coef_word_t  coef_data_i;
	sample_t     sample_i;
	logic        start_i;
	logic        busy_o;
	logic        done_o;
	logic        state_we_o;
	harm_idx_t   state_addr_o;
	state_pair_t state_data_o;
	sample_t     estimate_o;

	logic [31:0] lfsr_q;
	int          checks;
	int          errors;
	int          timeouts;
	int          checks_mark;
	int          errors_mark;

	resonator_bank dut (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.coef_we_i     (coef_we_i),
		.coef_addr_i   (coef_addr_i),
		.coef_data_i   (coef_data_i),
		.sample_i      (sample_i),
		.start_i       (start_i),
		.busy_o        (busy_o),
		.done_o        (done_o),
		.state_we_o    (state_we_o),
		.state_addr_o  (state_addr_o),
		.state_data_o  (state_data_o),
		.estimate_o    (estimate_o)
	);

	resonator_checker u_checker (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.coef_we_i     (coef_we_i),
		.coef_addr_i   (coef_addr_i),
		.coef_data_i   (coef_data_i),
		.sample_i      (sample_i),
		.start_i       (start_i),
		.busy_i        (busy_o),
		.done_i        (done_o),
		.state_we_i    (state_we_o),
		.state_addr_i  (state_addr_o),
		.state_data_i  (state_data_o),
		.estimate_i    (estimate_o),
		.checks_o      (checks),
		.errors_o      (errors)
	);

	always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			r      = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// 16 random bits sign-extended, so the magnitude stays below 0.5.
	function automatic sample_t rand_fix16();
		logic [31:0] r;
		r = take_bits(16);
		return sample_t'({{2{r[15]}}, r[15:0]});
	endfunction

	task automatic write_coef(input int addr, input coef_word_t data);
		@(negedge clk_i);
		coef_we_i   = 1'b1;
		coef_addr_i = coef_addr_t'(addr);
		coef_data_i = data;
		@(negedge clk_i);
		coef_we_i   = 1'b0;
	endtask

	task automatic load_harmonic(input int k, input sample_t c, input sample_t s, input sample_t g);
		write_coef(2 * k, {c, s});
		write_coef(2 * k + 1, {g, {`RES_DATA_W{1'b0}}});
	endtask

	task automatic set_count(input int n);
		write_coef(`RES_CNT_ADDR, coef_word_t'(n));
	endtask

	task automatic run_sample(input sample_t smp, input int pulse_at);
		int waited;
		waited = 0;
		@(negedge clk_i);
		sample_i = smp;
		start_i  = 1'b1;
		@(negedge clk_i);
		start_i  = 1'b0;
		sample_i = rand_fix16(); // the DUT must keep the sample taken at start.
		while (!done_o && waited < SAMPLE_CYCLES) begin
			start_i = (waited == pulse_at);
			@(negedge clk_i);
			start_i = 1'b0;
			waited++;
		end
		if (!done_o) begin
			$display("timeout: done_o did not arrive within %0d cycles of start", SAMPLE_CYCLES);
			timeouts++;
		end
	endtask

	task automatic close_test(input int num, input string name);
		$display("test %0d, %s: %0d checks, %0d errors", num, name,
			checks - checks_mark, errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		sample_t c;
		sample_t s;
		sample_t g;
		int      counts [6];
		clk_i         = 1'b0;
		harmonics_rst = 1'b1;
		coef_we_i     = 1'b0;
		coef_addr_i   = '0;
		coef_data_i   = '0;
		sample_i      = '0;
		start_i       = 1'b0;
		lfsr_q        = 32'h4a24_4420;
		timeouts      = 0;
		checks_mark   = 0;
		errors_mark   = 0;
		counts        = '{3, 1, 5, 8, 0, 11}; // 0 and 11 are clamped by the DUT.
		repeat (RESET_CYCLES) @(negedge clk_i);
		harmonics_rst = 1'b0;

		for (int k = 0; k < `RES_HARM_MAX; k++) begin
			c = rand_fix16();
			s = rand_fix16();
			load_harmonic(k, c, s, '0);
		end
		set_count(`RES_HARM_MAX);
		repeat (2) run_sample(rand_fix16(), -1);
		close_test(1, "zero gains after reset");

		load_harmonic(0, 18'sd52429, 18'sd39322, 18'sd16384); // cos 0.8, sin 0.6, gain 0.25.
		set_count(1);
		repeat (20) run_sample(rand_fix16(), -1);
		close_test(2, "single harmonic rotation");

		for (int k = 0; k < `RES_HARM_MAX; k++) begin
			c = rand_fix16();
			s = rand_fix16();
			g = rand_fix16();
			load_harmonic(k, c, s, g);
		end
		set_count(`RES_HARM_MAX);
		repeat (10) run_sample(rand_fix16(), -1);
		close_test(3, "full bank with random coefficients");

		foreach (counts[i]) begin
			set_count(counts[i]);
			run_sample(rand_fix16(), -1);
		end
		close_test(4, "count changes between samples");

		set_count(4);
		run_sample(rand_fix16(), 3);
		run_sample(rand_fix16(), 12); // lands in the write of the last harmonic.
		run_sample(rand_fix16(), -1);
		close_test(5, "start during busy");

		repeat (4) @(negedge clk_i);
		$display("summary: %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
			checks, errors, timeouts, dut.u_asserts.fail_count);
		if (errors == 0 && timeouts == 0 && dut.u_asserts.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- verif/resonator_checker.sv
`timescale 1ns/1ps
`include "resonator_defs.svh"

module resonator_checker (
	input  logic                            clk_i,
	input  logic                            harmonics_rst,
	input  logic                            coef_we_i,
	input  resonator_data_pkg::coef_addr_t  coef_addr_i,
	input  resonator_data_pkg::coef_word_t  coef_data_i,
	input  resonator_data_pkg::sample_t     sample_i,
	input  logic                            start_i,
	input  logic                            busy_i,
	input  logic                            done_i,
	input  logic                            state_we_i,
	input  resonator_data_pkg::harm_idx_t   state_addr_i,
	input  resonator_data_pkg::state_pair_t state_data_i,
	input  resonator_data_pkg::sample_t     estimate_i,
	output int                              checks_o,
	output int                              errors_o
);
	import resonator_data_pkg::*;

	coef_word_t  coef_copy [`RES_CNT_ADDR+1]; // mirror of what was written to the DUT.
	sample_t     model_x1 [`RES_HARM_MAX];
	sample_t     model_x2 [`RES_HARM_MAX];
	sample_t     model_est;
	sample_t     exp_est;
	sample_t     shown_est; // estimate_o as published at the last done_o.
	state_pair_t exp_data [$];
	harm_idx_t   exp_addr [$];
	int          cycle;
	int          start_cycle;
	int          exp_latency;
	logic        in_flight;

	function automatic int clamp_count(logic [3:0] word);
		if (word == 4'd0) return 1;
		if (word > `RES_HARM_MAX) return `RES_HARM_MAX;
		return int'(word);
	endfunction

	// Runs one sample through n harmonics, queues the expected writes and returns the estimate.
	function automatic sample_t predict_sample(sample_t smp, int n);
		sample_t err;
		sample_t c;
		sample_t s;
		sample_t g;
		sample_t sum;
		longint  acc1;
		longint  acc2;
		err = smp - model_est;
		sum = '0;
		for (int k = 0; k < n; k++) begin
			c = coef_copy[2*k][`RES_DATA_W +: `RES_DATA_W];
			s = coef_copy[2*k][0 +: `RES_DATA_W];
			g = coef_copy[2*k+1][`RES_DATA_W +: `RES_DATA_W];
			acc1 = longint'(c) * longint'(model_x1[k]) - longint'(s) * longint'(model_x2[k])
				+ longint'(g) * longint'(err);
			acc2 = longint'(s) * longint'(model_x1[k]) + longint'(c) * longint'(model_x2[k]);
			model_x1[k] = sample_t'(acc1 >>> `RES_FRAC_BITS); // wraps to 18 bits.
			model_x2[k] = sample_t'(acc2 >>> `RES_FRAC_BITS);
			exp_addr.push_back(harm_idx_t'(k));
			exp_data.push_back({model_x1[k], model_x2[k]});
			sum = sum + model_x1[k];
		end
		model_est = sum;
		return sum;
	endfunction

	task automatic report_mismatch(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		errors_o++;
	endtask

	always @(posedge clk_i) begin
		int n;
		if (harmonics_rst) begin
			for (int k = 0; k < `RES_HARM_MAX; k++) begin
				model_x1[k] = '0;
				model_x2[k] = '0;
			end
			for (int a = 0; a <= `RES_CNT_ADDR; a++) begin
				coef_copy[a] = '0;
			end
			model_est = '0;
			shown_est = '0;
			exp_data.delete();
			exp_addr.delete();
			in_flight = 1'b0;
			cycle     = 0;
			checks_o  = 0;
			errors_o  = 0;
		end else begin
			cycle++;
			// busy_o rises the cycle after start and falls together with done_o.
			if (busy_i !== (in_flight && !done_i)) begin
				report_mismatch($sformatf("busy_o is %b, expected %b",
					busy_i, in_flight && !done_i));
			end
			if (state_we_i) begin
				checks_o++;
				if (exp_data.size() == 0) begin
					report_mismatch($sformatf("unexpected state write to harmonic %0d", state_addr_i));
				end else begin
					if (state_addr_i !== exp_addr[0] || state_data_i !== exp_data[0]) begin
						report_mismatch($sformatf("state write expected %0d:%h, got %0d:%h",
							exp_addr[0], exp_data[0], state_addr_i, state_data_i));
					end
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
				end
			end
			if (done_i) begin
				checks_o++;
				if (!in_flight) begin
					report_mismatch("done_o without an accepted start");
				end else begin
					if (cycle - start_cycle != exp_latency) begin
						report_mismatch($sformatf("done_o after %0d cycles, expected %0d",
							cycle - start_cycle, exp_latency));
					end
					if (exp_data.size() != 0) begin
						report_mismatch($sformatf("%0d state writes missing", exp_data.size()));
					end
					if (estimate_i !== exp_est) begin
						report_mismatch($sformatf("estimate expected %h, got %h", exp_est, estimate_i));
					end
				end
				shown_est = estimate_i;
				in_flight = 1'b0;
			end else if (estimate_i !== shown_est) begin
				report_mismatch("estimate_o changed between done_o pulses");
			end
			if (start_i && !in_flight) begin
				n = clamp_count(coef_copy[`RES_CNT_ADDR][3:0]); // count word as it was before this edge.
				exp_latency = 3 * n + 2;
				exp_est     = predict_sample(sample_i, n);
				start_cycle = cycle;
				in_flight   = 1'b1;
			end
			if (coef_we_i && coef_addr_i <= `RES_CNT_ADDR) begin
				coef_copy[coef_addr_i] = coef_data_i;
			end
		end
	end

endmodule

//--- verif/resonator_asserts.sv
`timescale 1ns/1ps

module resonator_asserts (
	input logic                         clk_i,
	input logic                         harmonics_rst,
	input logic                         start_i,
	input logic                         busy_i,
	input logic                         done_i,
	input logic                         state_we_i,
	input resonator_ctrl_pkg::dp_step_t step_i
);
	import resonator_ctrl_pkg::*;

	int fail_count = 0;

	done_single: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		done_i |=> !done_i)
		else begin
			fail_count++;
			$error("done_o stayed high for more than one cycle");
		end

	write_in_busy: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		state_we_i |-> busy_i)
		else begin
			fail_count++;
			$error("state write seen while busy_o was low");
		end

	// the error step only ever follows an accepted start, so a restart would show up there.
	no_restart: assert property (@(posedge clk_i) disable iff (harmonics_rst)
		(start_i && busy_i) |=> (step_i != DP_ERROR))
		else begin
			fail_count++;
			$error("start_i during busy_o restarted the sequence");
		end

endmodule

bind resonator_bank resonator_asserts u_asserts (
	.clk_i         (clk_i),
	.harmonics_rst (harmonics_rst),
	.start_i       (start_i),
	.busy_i        (busy_o),
	.done_i        (done_o),
	.state_we_i    (state_we_o),
	.step_i        (dp_step)
);

//--- rtl/resonator_bank.sv
`timescale 1ns/1ps

module resonator_bank (
	input  logic                            clk_i,
	input  logic                            harmonics_rst,
	input  logic                            coef_we_i,
	input  resonator_data_pkg::coef_addr_t  coef_addr_i,
	input  resonator_data_pkg::coef_word_t  coef_data_i,
	input  resonator_data_pkg::sample_t     sample_i,
	input  logic                            start_i,
	output logic                            busy_o,
	output logic                            done_o,
	output logic                            state_we_o,
	output resonator_data_pkg::harm_idx_t   state_addr_o,
	output resonator_data_pkg::state_pair_t state_data_o,
	output resonator_data_pkg::sample_t     estimate_o
);
	import resonator_data_pkg::*;
	import resonator_ctrl_pkg::*;

	coef_addr_t coef_raddr;
	coef_word_t coef_rdata;
	logic       latch_count;
	logic [3:0] harm_count;
	dp_step_t   dp_step;
	harm_idx_t  harm_idx;

	coef_ram u_coef_ram (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.coef_we_i     (coef_we_i),
		.coef_addr_i   (coef_addr_i),
		.coef_data_i   (coef_data_i),
		.rd_addr_i     (coef_raddr),
		.latch_count_i (latch_count),
		.rd_data_o     (coef_rdata),
		.harm_count_o  (harm_count)
	);

	resonator_seq u_seq (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.start_i       (start_i),
		.harm_count_i  (harm_count),
		.rd_addr_o     (coef_raddr),
		.latch_count_o (latch_count),
		.step_o        (dp_step),
		.harm_idx_o    (harm_idx),
		.busy_o        (busy_o),
		.done_o        (done_o)
	);

	rotation_datapath u_datapath (
		.clk_i         (clk_i),
		.harmonics_rst (harmonics_rst),
		.sample_i      (sample_i),
		.step_i        (dp_step),
		.harm_idx_i    (harm_idx),
		.coef_i        (coef_rdata),
		.state_we_o    (state_we_o),
		.state_addr_o  (state_addr_o),
		.state_data_o  (state_data_o),
		.estimate_o    (estimate_o)
	);

endmodule

//--- rtl/rotation_datapath.sv
`timescale 1ns/1ps
`include "resonator_defs.svh"

module rotation_datapath (
	input  logic                            clk_i,
	input  logic                            harmonics_rst,
	input  resonator_data_pkg::sample_t     sample_i,
	input  resonator_ctrl_pkg::dp_step_t    step_i,
	input  resonator_data_pkg::harm_idx_t   harm_idx_i,
	input  resonator_data_pkg::coef_word_t  coef_i,
	output logic                            state_we_o,
	output resonator_data_pkg::harm_idx_t   state_addr_o,
	output resonator_data_pkg::state_pair_t state_data_o,
	output resonator_data_pkg::sample_t     estimate_o
);
	import resonator_data_pkg::*;
	import resonator_ctrl_pkg::*;

	state_pair_t state_q [`RES_HARM_MAX];

	sample_t  sample_q;
	sample_t  err_q;
	sample_t  sum_q;
	sample_t  est_q;
	logic     run_q;

	sample_t  x1_cur;
	sample_t  x2_cur;
	sample_t  cos_c;
	sample_t  sin_c;
	sample_t  gain_c;
	sample_t  x1_new;
	sample_t  x2_new;

	product_t rot1_q; // c*x1 - s*x2, still at full scale.
	product_t rot2_q; // s*x1 + c*x2.
	product_t acc1;
	logic     wr_step;

	assign x1_cur = state_q[harm_idx_i][`RES_DATA_W +: `RES_DATA_W];
	assign x2_cur = state_q[harm_idx_i][0 +: `RES_DATA_W];

	// in rotate coef_i holds {cos, sin}, in write it holds {gain, -}.
	assign cos_c  = coef_i[`RES_DATA_W +: `RES_DATA_W];
	assign sin_c  = coef_i[0 +: `RES_DATA_W];
	assign gain_c = coef_i[`RES_DATA_W +: `RES_DATA_W];

	// sums wrap at 36 bits, which leaves bits of the 18-bit result untouched.
	assign acc1   = rot1_q + gain_c * err_q;
	assign x1_new = acc1[`RES_FRAC_BITS +: `RES_DATA_W];
	assign x2_new = rot2_q[`RES_FRAC_BITS +: `RES_DATA_W];

	assign wr_step = (step_i == DP_WRITE) || (step_i == DP_FINAL);

	assign state_we_o   = wr_step;
	assign state_addr_o = harm_idx_i;
	assign state_data_o = {x1_new, x2_new};
	assign estimate_o   = est_q;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			for (int i = 0; i < `RES_HARM_MAX; i++) begin
				state_q[i] <= '0;
			end
			sum_q <= '0;
			est_q <= '0;
			run_q <= 1'b0;
		end else begin
			if (wr_step) begin
				state_q[harm_idx_i] <= {x1_new, x2_new};
			end
			case (step_i)
				DP_ERROR: begin
					sum_q <= '0;
					run_q <= 1'b1;
				end
				DP_WRITE: sum_q <= sum_q + x1_new;
				DP_FINAL: begin
					est_q <= sum_q + x1_new; // estimate holds until the next sample ends.
					run_q <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	// the sample is held from the start cycle, so the input may change afterwards.
	always_ff @(posedge clk_i) begin
		if (!run_q && step_i == DP_IDLE) begin
			sample_q <= sample_i;
		end
		if (step_i == DP_ERROR) begin
			err_q <= sample_q - est_q;
		end
		if (step_i == DP_ROTATE) begin
			rot1_q <= cos_c * x1_cur - sin_c * x2_cur;
			rot2_q <= sin_c * x1_cur + cos_c * x2_cur;
		end
	end

endmodule

//--- rtl/resonator_seq.sv
`timescale 1ns/1ps

module resonator_seq (
	input  logic                            clk_i,
	input  logic                            harmonics_rst,
	input  logic                            start_i,
	input  logic [3:0]                      harm_count_i,
	output resonator_data_pkg::coef_addr_t  rd_addr_o,
	output logic                            latch_count_o,
	output resonator_ctrl_pkg::dp_step_t    step_o,
	output resonator_data_pkg::harm_idx_t   harm_idx_o,
	output logic                            busy_o,
	output logic                            done_o
);
	import resonator_data_pkg::*;
	import resonator_ctrl_pkg::*;

	seq_state_t state_q;
	harm_idx_t  harm_idx_q;
	logic       last_harm;

	// harm_count_i is at least 1, so the subtraction cannot wrap.
	assign last_harm = ({1'b0, harm_idx_q} == harm_count_i - 4'd1);

	assign busy_o        = (state_q != SEQ_IDLE);
	assign latch_count_o = (state_q == SEQ_IDLE) && start_i;
	assign harm_idx_o    = harm_idx_q;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q    <= SEQ_IDLE;
			harm_idx_q <= '0;
			done_o     <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				SEQ_IDLE: begin
					if (start_i) begin
						state_q    <= SEQ_ERROR;
						harm_idx_q <= '0;
					end
				end
				SEQ_ERROR:  state_q <= SEQ_FETCH;
				SEQ_FETCH:  state_q <= SEQ_ROTATE;
				SEQ_ROTATE: state_q <= SEQ_WRITE;
				SEQ_WRITE: begin
					if (last_harm) begin
						state_q <= SEQ_IDLE;
						done_o  <= 1'b1;
					end else begin
						state_q    <= SEQ_FETCH;
						harm_idx_q <= harm_idx_q + 1'b1;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// cos/sin word is read in fetch so it lands in rotate; the gain word lands in write.
	always_comb begin
		case (state_q)
			SEQ_FETCH:  rd_addr_o = coef_addr_t'({harm_idx_q, 1'b0});
			SEQ_ROTATE: rd_addr_o = coef_addr_t'({harm_idx_q, 1'b1});
			default:    rd_addr_o = '0;
		endcase
	end

	always_comb begin
		case (state_q)
			SEQ_ERROR:  step_o = DP_ERROR;
			SEQ_ROTATE: step_o = DP_ROTATE;
			SEQ_WRITE:  step_o = last_harm ? DP_FINAL : DP_WRITE;
			default:    step_o = DP_IDLE;
		endcase
	end

endmodule

//--- rtl/coef_ram.sv
`timescale 1ns/1ps
`include "resonator_defs.svh"

module coef_ram (
	input  logic                            clk_i,
	input  logic                            harmonics_rst,
	input  logic                            coef_we_i,
	input  resonator_data_pkg::coef_addr_t  coef_addr_i,
	input  resonator_data_pkg::coef_word_t  coef_data_i,
	input  resonator_data_pkg::coef_addr_t  rd_addr_i,
	input  logic                            latch_count_i,
	output resonator_data_pkg::coef_word_t  rd_data_o,
	output logic [3:0]                      harm_count_o
);
	import resonator_data_pkg::*;

	coef_word_t mem [`RES_CNT_ADDR+1];
	logic [3:0] cnt_word;

	assign cnt_word = mem[`RES_CNT_ADDR][3:0];

	always_ff @(posedge clk_i) begin
		if (coef_we_i && coef_addr_i <= `RES_CNT_ADDR) begin
			mem[coef_addr_i] <= coef_data_i; // writes above the count word are dropped.
		end
		rd_data_o <= mem[rd_addr_i];
	end

	// the count is sampled once per sample, at start.
	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			harm_count_o <= 4'd1;
		end else if (latch_count_i) begin
			if (cnt_word == 4'd0) begin
				harm_count_o <= 4'd1;
			end else if (cnt_word > 4'(`RES_HARM_MAX)) begin
				harm_count_o <= 4'(`RES_HARM_MAX);
			end else begin
				harm_count_o <= cnt_word;
			end
		end
	end

endmodule

//--- rtl/resonator_ctrl_pkg.sv
package resonator_ctrl_pkg;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_ERROR,
		SEQ_FETCH,
		SEQ_ROTATE,
		SEQ_WRITE
	} seq_state_t;

	// one-hot step code for the datapath.
	typedef logic [3:0] dp_step_t;

	localparam dp_step_t DP_IDLE   = 4'b0000; // nothing to do, also used in fetch.
	localparam dp_step_t DP_ERROR  = 4'b0001;
	localparam dp_step_t DP_ROTATE = 4'b0010;
	localparam dp_step_t DP_WRITE  = 4'b0100;

	// write of the last active harmonic, which also publishes the estimate.
	localparam dp_step_t DP_FINAL  = 4'b1000;

endpackage

//--- rtl/resonator_data_pkg.sv
`include "resonator_defs.svh"

package resonator_data_pkg;

	// one input sample, estimate or state element.
	typedef logic signed [`RES_DATA_W-1:0] sample_t;

	// x1 sits in the upper half and x2 in the lower half.
	typedef logic [2*`RES_DATA_W-1:0] state_pair_t;

	// coefficient word, two 18-bit halves.
	typedef logic [2*`RES_DATA_W-1:0] coef_word_t;

	typedef logic [`RES_COEF_ADDR_W-1:0] coef_addr_t;

	// index of one harmonic in the bank.
	typedef logic [$clog2(`RES_HARM_MAX)-1:0] harm_idx_t;

	// full product of two sample_t values, also used for the sums of products.
	typedef logic signed [2*`RES_DATA_W-1:0] product_t;

endpackage

//--- include/resonator_defs.svh
`ifndef RESONATOR_DEFS_SVH
`define RESONATOR_DEFS_SVH

// all fixed-point values carry this many fraction bits.
`define RES_FRAC_BITS 16

// number of resonators the bank can hold.
`define RES_HARM_MAX 8

// one sample or one state element; a state pair is two of these.
`define RES_DATA_W 18

// coefficient memory address width.
`define RES_COEF_ADDR_W 5

// memory map of the coefficient memory:
//   word 2k   = {cos_k, sin_k}
//   word 2k+1 = {gain_k, unused}
//   word RES_CNT_ADDR holds the active harmonic count in bits 3:0.
`define RES_CNT_ADDR 16

`endif
